//--- dv/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen #(
	parameter int HALF_PERIOD  = 20, // 40 ns clock
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// reset released just after an edge, like the other inputs
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst_n = 1'b1;
	end

endmodule

//--- dv/tb_video_checker.sv
`timescale 1ns/100ps
`include "video_settings.svh"

module tb_video_checker (
	input  logic               clk,
	input  logic               mode_atm_n_pent,
	input  logic               mode_zx,
	input  logic               mode_p_16c,
	input  logic               mode_p_hmclr,
	input  logic               mode_a_hmclr,
	input  logic               mode_a_16c,
	input  logic               mode_a_text,
	input  logic               mode_pixf_14,
	input  video_pkg::vid_bw_t mode_bw,
	input  logic               hsync,
	input  logic               vsync,
	input  logic               border,
	input  logic               fetch_req,
	input  logic               start,       // one clk, expected values valid
	input  int                 test_idx,
	input  logic [7:0]         exp_flags,   // atm_n_pent down to pixf_14
	input  video_pkg::vid_bw_t exp_bw,
	input  int                 exp_fetch,   // fetches per visible line
	input  int                 n_tests,
	output int                 tests_done,
	output int                 pass_count,
	output int                 fail_count,
	output logic               report_done
);

	// lines to the first window after reset, plus slack
	localparam int LINE_LIMIT    = `VID_PENT_V_BEG + 8;
	localparam int LINE_CLKS     = `VID_H_TOTAL * 4; // four clk per strobe
	localparam int PENT_VIS_CLKS = (`VID_PENT_H_END - `VID_PENT_H_BEG + 1) * 4;
	localparam int ATM_VIS_CLKS  = (`VID_ATM_H_END - `VID_ATM_H_BEG + 1) * 4;

	function automatic string flag_name(input int idx);
		case (idx)
			7:       return "mode_atm_n_pent";
			6:       return "mode_zx";
			5:       return "mode_p_16c";
			4:       return "mode_p_hmclr";
			3:       return "mode_a_hmclr";
			2:       return "mode_a_16c";
			1:       return "mode_a_text";
			default: return "mode_pixf_14";
		endcase
	endfunction

	// one hsync rise to the next, sampled mid cycle
	task automatic count_line(output int fetches, output logic saw_border_low,
	                          output int line_clks, output int low_clks,
	                          output logic vs_in_win);
		logic hs_prev;
		logic rose;
		fetches        = 0;
		saw_border_low = 1'b0;
		line_clks      = 0;
		low_clks       = 0;
		vs_in_win      = 1'b0;
		rose           = 1'b0;
		hs_prev        = hsync;
		while (!rose) begin
			@(negedge clk);
			line_clks++;
			if (fetch_req) fetches++; // pulse lasts exactly one clk
			if (!border) begin
				saw_border_low = 1'b1;
				low_clks++;
				if (vsync) vs_in_win = 1'b1; // vsync lines lie below both windows
			end
			rose    = hsync && !hs_prev;
			hs_prev = hsync;
		end
	endtask

	task automatic run_check();
		logic [7:0] got_flags;
		int         errors;
		int         fetches;
		int         lines;
		logic       saw_vis;
		int         line_clks;
		int         low_clks;
		int         exp_low;
		logic       vs_in_win;
		errors    = 0;
		got_flags = {mode_atm_n_pent, mode_zx, mode_p_16c, mode_p_hmclr,
		             mode_a_hmclr, mode_a_16c, mode_a_text, mode_pixf_14};
		exp_low   = exp_flags[7] ? ATM_VIS_CLKS : PENT_VIS_CLKS; // window of the family
		for (int b = 7; b >= 0; b--) begin
			if (got_flags[b] !== exp_flags[b]) begin
				$display("Fail test %0d: %s got 0x%h expected 0x%h",
				         test_idx, flag_name(b), got_flags[b], exp_flags[b]);
				errors++;
			end
		end
		if (mode_bw !== exp_bw) begin
			$display("Fail test %0d: mode_bw got 0x%h expected 0x%h", test_idx, mode_bw, exp_bw);
			errors++;
		end

		// partial line, may hold the old mode
		count_line(fetches, saw_vis, line_clks, low_clks, vs_in_win);
		lines   = 0;
		saw_vis = 1'b0;
		while (!saw_vis && lines < LINE_LIMIT) begin
			count_line(fetches, saw_vis, line_clks, low_clks, vs_in_win);
			lines++;
		end

		if (!saw_vis) begin
			$display("test %0d: border never went low within %0d lines after the mode write",
			         test_idx, LINE_LIMIT);
			errors++;
		end else begin
			if (fetches != exp_fetch) begin
				$display("Fail test %0d: fetch_req count got 0x%0h expected 0x%0h",
				         test_idx, fetches, exp_fetch);
				errors++;
			end
			if (line_clks != LINE_CLKS) begin
				$display("Fail test %0d: hsync period got 0x%0h expected 0x%0h",
				         test_idx, line_clks, LINE_CLKS);
				errors++;
			end
			if (low_clks != exp_low) begin
				$display("Fail test %0d: border low clks got 0x%0h expected 0x%0h",
				         test_idx, low_clks, exp_low);
				errors++;
			end
			if (vs_in_win) begin
				$display("Fail test %0d: vsync got 0x1 expected 0x0 inside the window",
				         test_idx);
				errors++;
			end
		end

		if (errors == 0) begin
			pass_count++;
			$display("test %0d: pass, flags 0x%h bw %0d fetches %0d",
			         test_idx, got_flags, mode_bw, fetches);
		end else begin
			fail_count++;
			$display("test %0d: fail with %0d mismatches", test_idx, errors);
		end
	endtask

	initial begin
		tests_done  = 0;
		pass_count  = 0;
		fail_count  = 0;
		report_done = 1'b0;
		forever begin
			@(negedge clk);
			if (start) begin // seen on exactly one negedge
				run_check();
				tests_done++;
				if (tests_done == n_tests) begin
					$display("results: %0d passed, %0d failed", pass_count, fail_count);
					report_done = 1'b1;
				end
			end
		end
	end

endmodule

//--- dv/tb_video_front.sv
`timescale 1ns/100ps
`include "video_settings.svh"

module tb_video_front;

	localparam int MAX_TESTS = 32;
	localparam int LINE_CLKS = `VID_H_TOTAL * 4; // one s3 per four clk

	logic               clk;
	logic               rst_n;
	logic               port_wr;
	logic               port_sel;
	logic [2:0]         port_data;
	logic               mode_atm_n_pent;
	logic               mode_zx;
	logic               mode_p_16c;
	logic               mode_p_hmclr;
	logic               mode_a_hmclr;
	logic               mode_a_16c;
	logic               mode_a_text;
	logic               mode_pixf_14;
	video_pkg::vid_bw_t mode_bw;
	logic               hsync;
	logic               vsync;
	logic               border;
	logic               fetch_req;

	// stim table, one entry per test
	logic [1:0]             stim_wr    [MAX_TESTS]; // bit1 pentagon, bit0 atm
	video_pkg::pent_vmode_t stim_pent  [MAX_TESTS];
	video_pkg::atm_vmode_t  stim_atm   [MAX_TESTS];
	logic [7:0]             stim_flags [MAX_TESTS];
	video_pkg::vid_bw_t     stim_bw    [MAX_TESTS];
	int                     stim_fetch [MAX_TESTS];
	int                     n_tests;

	logic               start;
	int                 test_idx;
	logic [7:0]         exp_flags;
	video_pkg::vid_bw_t exp_bw;
	int                 exp_fetch;
	int                 tests_done;
	int                 pass_count;
	int                 fail_count;
	logic               report_done;
	int                 cycle_count;
	int                 cycle_limit;
	logic               limit_ready;

	tb_clk_gen u_clk_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	video_front uut (
		.clk             (clk),
		.rst_n           (rst_n),
		.port_wr         (port_wr),
		.port_sel        (port_sel),
		.port_data       (port_data),
		.mode_atm_n_pent (mode_atm_n_pent),
		.mode_zx         (mode_zx),
		.mode_p_16c      (mode_p_16c),
		.mode_p_hmclr    (mode_p_hmclr),
		.mode_a_hmclr    (mode_a_hmclr),
		.mode_a_16c      (mode_a_16c),
		.mode_a_text     (mode_a_text),
		.mode_pixf_14    (mode_pixf_14),
		.mode_bw         (mode_bw),
		.hsync           (hsync),
		.vsync           (vsync),
		.border          (border),
		.fetch_req       (fetch_req)
	);

	tb_video_checker u_checker (
		.clk             (clk),
		.mode_atm_n_pent (mode_atm_n_pent),
		.mode_zx         (mode_zx),
		.mode_p_16c      (mode_p_16c),
		.mode_p_hmclr    (mode_p_hmclr),
		.mode_a_hmclr    (mode_a_hmclr),
		.mode_a_16c      (mode_a_16c),
		.mode_a_text     (mode_a_text),
		.mode_pixf_14    (mode_pixf_14),
		.mode_bw         (mode_bw),
		.hsync           (hsync),
		.vsync           (vsync),
		.border          (border),
		.fetch_req       (fetch_req),
		.start           (start),
		.test_idx        (test_idx),
		.exp_flags       (exp_flags),
		.exp_bw          (exp_bw),
		.exp_fetch       (exp_fetch),
		.n_tests         (n_tests),
		.tests_done      (tests_done),
		.pass_count      (pass_count),
		.fail_count      (fail_count),
		.report_done     (report_done)
	);

	task automatic read_stim(output int count);
		int    fd;
		int    rc;
		string line;
		int    wr_v;
		int    pent_v;
		int    atm_v;
		int    flags_v;
		int    bw_v;
		int    fetch_v;
		count = 0;
		fd    = $fopen("dv/video_stim.txt", "r");
		if (fd == 0) begin
			$display("cannot open dv/video_stim.txt");
		end else begin
			while (!$feof(fd) && count < MAX_TESTS) begin
				rc = $fgets(line, fd);
				if (rc > 0 && line.len() > 1 && line[0] != "#") begin // skip notes and blanks
					rc = $sscanf(line, "%h %h %h %h %h %d",
					             wr_v, pent_v, atm_v, flags_v, bw_v, fetch_v);
					if (rc == 6) begin
						stim_wr[count]    = wr_v[1:0];
						stim_pent[count]  = pent_v[1:0];
						stim_atm[count]   = atm_v[2:0];
						stim_flags[count] = flags_v[7:0];
						stim_bw[count]    = bw_v[1:0];
						stim_fetch[count] = fetch_v;
						count++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// one clk write pulse, data held with it
	task automatic write_reg(input logic sel, input logic [2:0] data);
		@(posedge clk);
		#2;
		port_wr   = 1'b1;
		port_sel  = sel;
		port_data = data;
		@(posedge clk); // register loads here
		#2;
		port_wr = 1'b0;
	endtask

	task automatic run_tests();
		for (int i = 0; i < n_tests; i++) begin
			if (stim_wr[i][1]) write_reg(1'b0, {1'b0, stim_pent[i]});
			if (stim_wr[i][0]) write_reg(1'b1, stim_atm[i]);
			repeat (8) @(posedge clk); // decoder settles within 5
			#2;
			exp_flags = stim_flags[i];
			exp_bw    = stim_bw[i];
			exp_fetch = stim_fetch[i];
			test_idx  = i + 1;
			start     = 1'b1;
			@(posedge clk);
			#2;
			start = 1'b0;
			wait (tests_done == i + 1);
		end
	endtask

	// run limit, set once the test count is known
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (limit_ready && cycle_count >= cycle_limit) begin
			$display("timeout after %0d cycles, %0d of %0d tests finished",
			         cycle_count, tests_done, n_tests);
			$display("Test FAILED");
			$finish;
		end
	end

	initial begin
		port_wr     = 1'b0;
		port_sel    = 1'b0;
		port_data   = 3'd0;
		start       = 1'b0;
		test_idx    = 0;
		exp_flags   = 8'h00;
		exp_bw      = 2'd0;
		exp_fetch   = 0;
		cycle_count = 0;
		cycle_limit = 0;
		limit_ready = 1'b0;
		read_stim(n_tests);
		if (n_tests == 0) begin
			$display("no test lines read from the stim file");
			$display("Test FAILED");
			$finish;
		end else begin
			cycle_limit = 16 + 64 * LINE_CLKS + n_tests * 3 * LINE_CLKS;
			limit_ready = 1'b1;
			@(posedge clk);
			wait (rst_n);
			run_tests();
			wait (report_done);
			if (fail_count == 0) begin
				$display("Test OK");
			end else begin
				$display("Test FAILED");
			end
			$finish;
		end
	end

endmodule

//--- dv/video_stim.txt
# wr pent atm flags bw fetches (wr bit1 writes pentagon, bit0 atm, 0 keeps reset values)
# flags hex bits 7..0: atm_n_pent zx p_16c p_hmclr a_hmclr a_16c a_text pixf_14
0 0 3 40 0 32
3 1 3 10 0 32
3 2 3 20 1 64
3 3 3 40 0 32
3 0 2 89 1 80
3 0 0 84 1 80
3 0 6 83 1 80
3 2 5 00 1 64
1 2 6 83 1 80
2 1 6 83 1 80
1 1 3 10 0 32
3 0 5 40 1 64
3 0 3 40 0 32

//--- hw/video_fetch_sched.sv
`timescale 1ns/100ps
`include "video_settings.svh"

module video_fetch_sched (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 s3,
	input  logic                 visible,   // window level from the raster
	input  video_pkg::vid_bw_t   mode_bw,
	output logic                 fetch_req  // one clk, coincident with s3
);

	logic [2:0] strobe_cnt; // visible strobes since window start, modulo 8
	logic [2:0] period_mask;
	logic       visible_d;

	// periods are powers of two, so a mask picks the multiples
	// reserved classes fall back to the 1/4 rate
	assign period_mask = (mode_bw == `VID_BW_1_8) ? 3'(`VID_FETCH_P8 - 1)
	                                              : 3'(`VID_FETCH_P4 - 1);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			strobe_cnt <= 3'd0;
			visible_d  <= 1'b0;
		end else begin
			visible_d <= visible;
			if (visible && !visible_d) begin
				strobe_cnt <= 3'd0; // window opened, restart the count
			end else if (s3 && visible) begin
				strobe_cnt <= strobe_cnt + 3'd1;
			end
		end
	end

	assign fetch_req = s3 && visible && ((strobe_cnt & period_mask) == 3'd0);

endmodule

//--- hw/video_front.sv
`timescale 1ns/100ps

module video_front (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 port_wr,
	input  logic                 port_sel,
	input  logic [2:0]           port_data,
	output logic                 mode_atm_n_pent,
	output logic                 mode_zx,
	output logic                 mode_p_16c,
	output logic                 mode_p_hmclr,
	output logic                 mode_a_hmclr,
	output logic                 mode_a_16c,
	output logic                 mode_a_text,
	output logic                 mode_pixf_14,
	output video_pkg::vid_bw_t   mode_bw,
	output logic                 hsync,
	output logic                 vsync,
	output logic                 border,
	output logic                 fetch_req
);

	video_pkg::pent_vmode_t pent_vmode;
	video_pkg::atm_vmode_t  atm_vmode;
	logic                   s3;      // shared phase strobe
	logic                   visible;

	video_port_regs u_port_regs (
		.clk        (clk),
		.rst_n      (rst_n),
		.port_wr    (port_wr),
		.port_sel   (port_sel),
		.port_data  (port_data),
		.pent_vmode (pent_vmode),
		.atm_vmode  (atm_vmode)
	);

	video_modedecode u_modedecode (
		.clk             (clk),
		.rst_n           (rst_n),
		.s3              (s3),
		.pent_vmode      (pent_vmode),
		.atm_vmode       (atm_vmode),
		.mode_atm_n_pent (mode_atm_n_pent),
		.mode_zx         (mode_zx),
		.mode_p_16c      (mode_p_16c),
		.mode_p_hmclr    (mode_p_hmclr),
		.mode_a_hmclr    (mode_a_hmclr),
		.mode_a_16c      (mode_a_16c),
		.mode_a_text     (mode_a_text),
		.mode_pixf_14    (mode_pixf_14),
		.mode_bw         (mode_bw)
	);

	// positions go to the pixel side, which is not part of this block
	video_raster u_raster (
		.clk             (clk),
		.rst_n           (rst_n),
		.mode_atm_n_pent (mode_atm_n_pent),
		.s3              (s3),
		.hpos            (),
		.vpos            (),
		.visible         (visible),
		.hsync           (hsync),
		.vsync           (vsync),
		.border          (border)
	);

	video_fetch_sched u_fetch_sched (
		.clk       (clk),
		.rst_n     (rst_n),
		.s3        (s3),
		.visible   (visible),
		.mode_bw   (mode_bw),
		.fetch_req (fetch_req)
	);

endmodule

//--- hw/video_modedecode.sv
`timescale 1ns/100ps
`include "video_settings.svh"

module video_modedecode (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     s3,              // phase strobe, decode updates here
	input  video_pkg::pent_vmode_t   pent_vmode,
	input  video_pkg::atm_vmode_t    atm_vmode,
	output logic                     mode_atm_n_pent, // 1 - atm geometry, 0 - pentagon
	output logic                     mode_zx,
	output logic                     mode_p_16c,
	output logic                     mode_p_hmclr,
	output logic                     mode_a_hmclr,
	output logic                     mode_a_16c,
	output logic                     mode_a_text,
	output logic                     mode_pixf_14,    // 14 MHz pixel clock, else 7
	output video_pkg::vid_bw_t       mode_bw
);

	logic is_atm;      // one of the three defined atm modes
	logic pent_active; // atm code hands the screen to the pentagon register
	logic pent_zx;     // pentagon value reads as zx
	video_pkg::vid_bw_t bw_next;

	always_comb begin
		case (atm_vmode)
			`VID_ATM_HMCLR,
			`VID_ATM_16C,
			`VID_ATM_TEXT: is_atm = 1'b1;
			default:       is_atm = 1'b0; // undefined codes keep pentagon geometry
		endcase
	end

	assign pent_active = (atm_vmode == `VID_ATM_ZX);
	assign pent_zx     = (pent_vmode == `VID_PENT_ZX) || (pent_vmode == 2'b11);

	// 16 color pentagon doubles the fetch rate, every atm mode needs it too
	assign bw_next = (pent_active && (pent_vmode != `VID_PENT_16C)) ? `VID_BW_1_8
	                                                                 : `VID_BW_1_4;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mode_atm_n_pent <= 1'b0;
			mode_zx         <= 1'b0;
			mode_p_16c      <= 1'b0;
			mode_p_hmclr    <= 1'b0;
			mode_a_hmclr    <= 1'b0;
			mode_a_16c      <= 1'b0;
			mode_a_text     <= 1'b0;
			mode_pixf_14    <= 1'b0;
			mode_bw         <= `VID_BW_1_8;
		end else if (s3) begin
			mode_atm_n_pent <= is_atm;

			// zx also covers undefined atm codes when pentagon says zx
			mode_zx <= !is_atm && pent_zx;

			// pentagon specific modes only with atm in zx mode
			mode_p_16c   <= pent_active && (pent_vmode == `VID_PENT_16C);
			mode_p_hmclr <= pent_active && (pent_vmode == `VID_PENT_HMCLR);

			mode_a_hmclr <= (atm_vmode == `VID_ATM_HMCLR); // 640 wide
			mode_a_16c   <= (atm_vmode == `VID_ATM_16C);   // 320 wide
			mode_a_text  <= (atm_vmode == `VID_ATM_TEXT);  // 80 columns

			// both 640 pixel modes run the fast pixel clock
			mode_pixf_14 <= (atm_vmode == `VID_ATM_HMCLR) || (atm_vmode == `VID_ATM_TEXT);

			mode_bw <= bw_next;
		end
	end

endmodule

//--- hw/video_pkg.sv
package video_pkg;

	// mode register contents as written by the cpu
	typedef logic [1:0] pent_vmode_t; // pentagon mode, 00 is plain zx
	typedef logic [2:0] atm_vmode_t;  // atm mode, 011 hands control to pentagon

	// memory bandwidth class requested by the current mode
	// 0 - one fetch per 8 strobes, 1 - one per 4
	// 2 and 3 are reserved for denser modes
	typedef logic [1:0] vid_bw_t;

	// raster positions, counted in s3 strobes and lines
	typedef logic [8:0] hpos_t; // 0..447
	typedef logic [8:0] vpos_t; // 0..319

endpackage

//--- hw/video_port_regs.sv
`timescale 1ns/100ps
`include "video_settings.svh"

module video_port_regs (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     port_wr,   // one clk write pulse from the bus side
	input  logic                     port_sel,  // 0 - pentagon, 1 - atm
	input  logic [2:0]               port_data,
	output video_pkg::pent_vmode_t   pent_vmode,
	output video_pkg::atm_vmode_t    atm_vmode
);

	// both registers come up in plain zx
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pent_vmode <= `VID_PENT_ZX;
			atm_vmode  <= `VID_ATM_ZX;
		end else if (port_wr) begin
			// only the addressed register changes
			if (port_sel) begin
				atm_vmode <= port_data;
			end else begin
				pent_vmode <= port_data[1:0]; // top bit ignored
			end
		end
	end

endmodule

//--- hw/video_raster.sv
`timescale 1ns/100ps
`include "video_settings.svh"

module video_raster (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                mode_atm_n_pent, // family from the decoder
	output logic                s3,              // one clk in four
	output video_pkg::hpos_t    hpos,
	output video_pkg::vpos_t    vpos,
	output logic                visible,
	output logic                hsync,
	output logic                vsync,
	output logic                border
);

	logic [1:0]       phase;
	logic             line_atm; // family held for the whole line
	logic             h_last;
	logic             v_last;
	logic             in_win;
	logic             hsync_on;
	logic             vsync_on;
	video_pkg::hpos_t h_beg;
	video_pkg::hpos_t h_end;
	video_pkg::vpos_t v_beg;
	video_pkg::vpos_t v_end;

	// phase counter, s3 fires as phase leaves 3
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			phase <= 2'd0;
			s3    <= 1'b0;
		end else begin
			phase <= phase + 2'd1;
			s3    <= (phase == 2'd3);
		end
	end

	assign h_last = (hpos == video_pkg::hpos_t'(`VID_H_TOTAL - 1));
	assign v_last = (vpos == video_pkg::vpos_t'(`VID_V_TOTAL - 1));

	// h counts strobes, v counts lines
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hpos     <= '0;
			vpos     <= '0;
			line_atm <= 1'b0; // pentagon geometry out of reset
		end else if (s3) begin
			if (h_last) begin
				hpos     <= '0;
				line_atm <= mode_atm_n_pent; // sampled only at line start
				vpos     <= v_last ? '0 : vpos + 9'd1;
			end else begin
				hpos <= hpos + 9'd1;
			end
		end
	end

	// window bounds for the latched family
	assign h_beg = line_atm ? video_pkg::hpos_t'(`VID_ATM_H_BEG) : video_pkg::hpos_t'(`VID_PENT_H_BEG);
	assign h_end = line_atm ? video_pkg::hpos_t'(`VID_ATM_H_END) : video_pkg::hpos_t'(`VID_PENT_H_END);
	assign v_beg = line_atm ? video_pkg::vpos_t'(`VID_ATM_V_BEG) : video_pkg::vpos_t'(`VID_PENT_V_BEG);
	assign v_end = line_atm ? video_pkg::vpos_t'(`VID_ATM_V_END) : video_pkg::vpos_t'(`VID_PENT_V_END);

	assign in_win = (hpos >= h_beg) && (hpos <= h_end) && (vpos >= v_beg) && (vpos <= v_end);

	assign hsync_on = (hpos >= video_pkg::hpos_t'(`VID_HSYNC_BEG))
	               && (hpos < video_pkg::hpos_t'(`VID_HSYNC_BEG + `VID_HSYNC_LEN));
	assign vsync_on = (vpos >= video_pkg::vpos_t'(`VID_VSYNC_BEG))
	               && (vpos < video_pkg::vpos_t'(`VID_VSYNC_BEG + `VID_VSYNC_LEN));

	// levels settle one clk after the strobe that moved hpos
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			visible <= 1'b0;
			border  <= 1'b1;
			hsync   <= 1'b0;
			vsync   <= 1'b0;
		end else begin
			visible <= in_win;
			border  <= !in_win;
			hsync   <= hsync_on;
			vsync   <= vsync_on;
		end
	end

endmodule

//--- hw/video_settings.svh
`ifndef VIDEO_SETTINGS_SVH
`define VIDEO_SETTINGS_SVH

// atm mode codes
`define VID_ATM_ZX      3'b011 // pentagon register is in charge
`define VID_ATM_HMCLR   3'b010 // 640x200 hardware multicolor
`define VID_ATM_16C     3'b000 // 320x200 16 colors
`define VID_ATM_TEXT    3'b110 // 80x25 text

// pentagon mode codes, 11 acts as zx
`define VID_PENT_ZX     2'b00
`define VID_PENT_HMCLR  2'b01
`define VID_PENT_16C    2'b10

// bandwidth classes
`define VID_BW_1_8      2'b00
`define VID_BW_1_4      2'b01

// raster totals, h in s3 strobes
`define VID_H_TOTAL     448
`define VID_V_TOTAL     320
`define VID_HSYNC_BEG   368
`define VID_HSYNC_LEN   32
`define VID_VSYNC_BEG   280
`define VID_VSYNC_LEN   4

// visible windows, bounds inclusive
`define VID_PENT_H_BEG  64
`define VID_PENT_H_END  319
`define VID_PENT_V_BEG  64
`define VID_PENT_V_END  255
`define VID_ATM_H_BEG   32
`define VID_ATM_H_END   351
`define VID_ATM_V_BEG   60
`define VID_ATM_V_END   259

// fetch periods in strobes
`define VID_FETCH_P8    8
`define VID_FETCH_P4    4

`endif

//--- run_sim.sh
#!/bin/sh
# build with verilator, run from the project root, judge the run by its pass line
verilator --binary --timing --timescale 1ns/100ps -f vlog.f \
	--top-module tb_video_front -o tb_video_front_sim || exit 1
out=$(./obj_dir/tb_video_front_sim)
echo "$out"
echo "$out" | grep -qx "Test OK" && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- vlog.f
+incdir+hw
hw/video_pkg.sv
hw/video_port_regs.sv
hw/video_modedecode.sv
hw/video_raster.sv
hw/video_fetch_sched.sv
hw/video_front.sv
dv/tb_clk_gen.sv
dv/tb_video_checker.sv
dv/tb_video_front.sv
